//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_TEXT ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/alu.sv
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  wire func3_t func3,
    input  wire         func7_b5,
    input  wire         alu_imm_f,
    input  wire word_t  d_rs1,
    input  wire word_t  d_rs2,
    output word_t       alu_rs,
    output logic        branch_jump
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;
    word_t      sra_res;

    assign shamt   = d_rs2[4:0];
    assign eq      = (d_rs1 == d_rs2);
    assign lt_s    = ($signed(d_rs1) < $signed(d_rs2));
    assign lt_u    = (d_rs1 < d_rs2);
    assign sra_res = $signed(d_rs1) >>> shamt;

    always_comb begin
        case (func3)
            // sub only for register form, bit 30 of an immediate means nothing here
            3'b000: alu_rs = (func7_b5 && !alu_imm_f) ? d_rs1 - d_rs2 : d_rs1 + d_rs2;
            3'b001: alu_rs = d_rs1 << shamt;
            3'b010: alu_rs = word_t'(lt_s);
            3'b011: alu_rs = word_t'(lt_u);
            3'b100: alu_rs = d_rs1 ^ d_rs2;
            3'b101: alu_rs = func7_b5 ? sra_res : d_rs1 >> shamt;
            3'b110: alu_rs = d_rs1 | d_rs2;
            default: alu_rs = d_rs1 & d_rs2;
        endcase
    end

    // branch condition on the same operand pair
    always_comb begin
        case (func3)
            3'b000: branch_jump = eq;
            3'b001: branch_jump = !eq;
            3'b100: branch_jump = lt_s;
            3'b101: branch_jump = !lt_s;
            3'b110: branch_jump = lt_u;
            3'b111: branch_jump = !lt_u;
            default: branch_jump = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/cpu.sv
`include "cpu_cfg.svh"

`default_nettype none

module cpu
    import cpu_pkg::*;
(
    input  wire        clk,
    input  wire        rstn,
    output iaddr_t     a_inst,
    input  wire inst_t d_inst,
    output daddr_t     a_mem,
    output word_t      sd_mem,
    input  wire word_t ld_mem,
    output strobe_t    mem_write_flag,
    output logic       mem_read_flag
);

    phase_t phase;
    word_t  pc;

    // register file ports
    logic      reg_flag;
    reg_addr_t reg_a_rd;
    word_t     reg_d_rd;
    reg_addr_t reg_a_rs1;
    reg_addr_t reg_a_rs2;
    word_t     reg_d_rs1;
    word_t     reg_d_rs2;

    // fetch to decode
    logic  fetch_order;
    logic  fetched;
    inst_t inst_f;
    inst_t inst_fd;
    word_t pc_fd;

    // decode outputs
    logic      alu_d, alu_imm_f_d, mem_d, branch_d, jump_d, subst_d;
    word_t     d_rs1_d, d_rs2_d, d_rs3_d;
    reg_addr_t a_rd_d;
    opcode_t   opecode_d;
    func3_t    func3_d;
    logic      func7_b5_d;

    // decode to execute
    logic      alu_de, alu_imm_f_de, mem_de, branch_de, jump_de, subst_de;
    word_t     d_rs1_de, d_rs2_de, d_rs3_de;
    reg_addr_t a_rd_de;
    opcode_t   opecode_de;
    func3_t    func3_de;
    logic      func7_b5_de;
    word_t     pc_de;

    // execute to write
    logic  write_ew;
    word_t d_rd_ew;
    word_t next_pc_ew;

    // execute units
    word_t alu_rs;
    logic  branch_jump;
    logic  mem_flag;
    logic  mem_io;
    word_t d_dr_mem;
    logic  mem_accessed;
    word_t pc_plus4;
    word_t next_pc;
    word_t exec_val;

    regs regs_i (
        .clk(clk), .rstn(rstn), .reg_flag(reg_flag), .reg_a_rd(reg_a_rd),
        .reg_d_rd(reg_d_rd), .reg_a_rs1(reg_a_rs1), .reg_a_rs2(reg_a_rs2),
        .reg_d_rs1(reg_d_rs1), .reg_d_rs2(reg_d_rs2)
    );

    fetch fetch_i (
        .clk(clk), .rstn(rstn), .fetch_order(fetch_order), .fetched(fetched),
        .pc(pc), .inst_f(inst_f), .a_inst(a_inst), .d_inst(d_inst)
    );

    decode decode_i (
        .inst_fd(inst_fd), .pc_fd(pc_fd), .reg_a_rs1(reg_a_rs1), .reg_a_rs2(reg_a_rs2),
        .reg_d_rs1(reg_d_rs1), .reg_d_rs2(reg_d_rs2), .alu_d(alu_d),
        .alu_imm_f_d(alu_imm_f_d), .mem_d(mem_d), .branch_d(branch_d), .jump_d(jump_d),
        .subst_d(subst_d), .d_rs1_d(d_rs1_d), .d_rs2_d(d_rs2_d), .d_rs3_d(d_rs3_d),
        .a_rd_d(a_rd_d), .opecode_d(opecode_d), .func3_d(func3_d), .func7_b5_d(func7_b5_d)
    );

    alu alu_i (
        .func3(func3_de), .func7_b5(func7_b5_de), .alu_imm_f(alu_imm_f_de),
        .d_rs1(d_rs1_de), .d_rs2(d_rs2_de), .alu_rs(alu_rs), .branch_jump(branch_jump)
    );

    memory memory_i (
        .clk(clk), .rstn(rstn), .mem_flag(mem_flag), .mem_io(mem_io), .func3(func3_de),
        .d_rs1(d_rs1_de), .d_rs2(d_rs2_de), .d_dr_mem(d_dr_mem), .mem_accessed(mem_accessed),
        .a_mem(a_mem), .sd_mem(sd_mem), .ld_mem(ld_mem), .mem_write_flag(mem_write_flag),
        .mem_read_flag(mem_read_flag)
    );

    // next pc and result for the non-memory classes
    assign pc_plus4 = pc_de + 32'd4;

    always_comb begin
        next_pc = pc_plus4;
        if (branch_de && branch_jump) begin
            next_pc = d_rs3_de;
        end else if (jump_de) begin
            next_pc = d_rs1_de;
        end
    end

    always_comb begin
        if (jump_de) begin
            exec_val = pc_plus4;
        end else if (subst_de) begin
            exec_val = d_rs3_de;
        end else begin
            exec_val = alu_rs;
        end
    end

    // phase controller
    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase        <= PH_FETCH;
            pc           <= `RESET_PC;
            fetch_order  <= 1'b0;
            reg_flag     <= 1'b0;
            mem_flag     <= 1'b0;
            write_ew     <= 1'b0;
            alu_de       <= 1'b0;
            alu_imm_f_de <= 1'b0;
            mem_de       <= 1'b0;
            branch_de    <= 1'b0;
            jump_de      <= 1'b0;
            subst_de     <= 1'b0;
        end else begin
            case (phase)
                PH_FETCH: begin
                    fetch_order <= 1'b1;
                    reg_flag    <= 1'b0;
                    phase       <= PH_FETCH_WAIT;
                end
                PH_FETCH_WAIT: begin
                    fetch_order <= 1'b0;
                    if (fetched) begin
                        phase <= PH_DECODE;
                    end
                end
                PH_DECODE: begin
                    alu_de       <= alu_d;
                    alu_imm_f_de <= alu_imm_f_d;
                    mem_de       <= mem_d;
                    branch_de    <= branch_d;
                    jump_de      <= jump_d;
                    subst_de     <= subst_d;
                    phase        <= PH_EXECUTE;
                end
                PH_EXECUTE: begin
                    if (mem_de) begin
                        mem_flag <= 1'b1;
                        phase    <= PH_EXECUTE_WAIT;
                    end else begin
                        // unknown opcodes fall through with no write
                        write_ew <= alu_de || jump_de || subst_de;
                        phase    <= PH_WRITE;
                    end
                end
                PH_EXECUTE_WAIT: begin
                    mem_flag <= 1'b0;
                    if (mem_accessed) begin
                        write_ew <= (opecode_de == OP_LOAD);
                        phase    <= PH_WRITE;
                    end
                end
                PH_WRITE: begin
                    reg_flag <= write_ew;
                    pc       <= {next_pc_ew[31:2], 2'b00};
                    phase    <= PH_FETCH;
                end
                default: phase <= PH_FETCH;
            endcase
        end
    end

    // stage data registers
    always_ff @(posedge clk) begin
        case (phase)
            PH_FETCH_WAIT: begin
                if (fetched) begin
                    inst_fd <= inst_f;
                    pc_fd   <= pc;
                end
            end
            PH_DECODE: begin
                d_rs1_de    <= d_rs1_d;
                d_rs2_de    <= d_rs2_d;
                d_rs3_de    <= d_rs3_d;
                a_rd_de     <= a_rd_d;
                opecode_de  <= opecode_d;
                func3_de    <= func3_d;
                func7_b5_de <= func7_b5_d;
                pc_de       <= pc_fd;
            end
            PH_EXECUTE: begin
                next_pc_ew <= next_pc;
                d_rd_ew    <= exec_val;
                mem_io     <= (opecode_de == OP_STORE);
            end
            PH_EXECUTE_WAIT: begin
                if (mem_accessed) begin
                    d_rd_ew <= d_dr_mem;
                end
            end
            PH_WRITE: begin
                reg_a_rd <= a_rd_de;
                reg_d_rd <= d_rd_ew;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data and instruction word widths
`define LEN_WORD 32
`define LEN_INST 32

// register index, 32 architectural registers
`define LEN_REG_ADDR 5

// word address widths of the two memories
// 4 KiB each, addressed by pc bits 11 down to 2
`define LEN_MEMISTR_ADDR 10
`define LEN_MEMDATA_ADDR 10

// first instruction fetched after reset
`define RESET_PC 32'h0000_0000

`endif

//--- hdl/cpu_pkg.sv
`include "cpu_cfg.svh"

`default_nettype none

package cpu_pkg;

    typedef logic [`LEN_WORD-1:0]         word_t;
    typedef logic [`LEN_INST-1:0]         inst_t;
    typedef logic [`LEN_REG_ADDR-1:0]     reg_addr_t;
    typedef logic [`LEN_MEMISTR_ADDR-1:0] iaddr_t;
    typedef logic [`LEN_MEMDATA_ADDR-1:0] daddr_t;
    typedef logic [3:0]                   strobe_t;
    typedef logic [2:0]                   func3_t;

    // rv32i major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_ALU    = 7'b0110011,
        OP_ALUI   = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_t;

    // one-hot controller phases
    typedef enum logic [5:0] {
        PH_FETCH        = 6'b000001,
        PH_FETCH_WAIT   = 6'b000010,
        PH_DECODE       = 6'b000100,
        PH_EXECUTE      = 6'b001000,
        PH_EXECUTE_WAIT = 6'b010000,
        PH_WRITE        = 6'b100000
    } phase_t;

    // field positions in the instruction word
    localparam int OPCODE_LSB   = 0;
    localparam int RD_LSB       = 7;
    localparam int FUNC3_LSB    = 12;
    localparam int RS1_LSB      = 15;
    localparam int RS2_LSB      = 20;
    localparam int FUNC7_B5_POS = 30;
    localparam int SIGN_POS     = 31;

    // load/store size codes in func3
    localparam func3_t F3_B  = 3'b000;
    localparam func3_t F3_H  = 3'b001;
    localparam func3_t F3_BU = 3'b100;
    localparam func3_t F3_HU = 3'b101;

endpackage

`default_nettype wire

//--- hdl/decode.sv
`default_nettype none

module decode
    import cpu_pkg::*;
(
    input  wire inst_t inst_fd,
    input  wire word_t pc_fd,
    output reg_addr_t  reg_a_rs1,
    output reg_addr_t  reg_a_rs2,
    input  wire word_t reg_d_rs1,
    input  wire word_t reg_d_rs2,
    output logic       alu_d,
    output logic       alu_imm_f_d,
    output logic       mem_d,
    output logic       branch_d,
    output logic       jump_d,
    output logic       subst_d,
    output word_t      d_rs1_d,
    output word_t      d_rs2_d,
    output word_t      d_rs3_d,
    output reg_addr_t  a_rd_d,
    output opcode_t    opecode_d,
    output func3_t     func3_d,
    output logic       func7_b5_d
);

    logic  sign;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    word_t jalr_sum;

    // field extraction
    assign opecode_d  = opcode_t'(inst_fd[OPCODE_LSB +: 7]);
    assign a_rd_d     = inst_fd[RD_LSB +: $bits(reg_addr_t)];
    assign func3_d    = inst_fd[FUNC3_LSB +: $bits(func3_t)];
    assign func7_b5_d = inst_fd[FUNC7_B5_POS];
    assign reg_a_rs1  = inst_fd[RS1_LSB +: $bits(reg_addr_t)];
    assign reg_a_rs2  = inst_fd[RS2_LSB +: $bits(reg_addr_t)];

    // immediates, all sign-extended from bit 31
    assign sign  = inst_fd[SIGN_POS];
    assign imm_i = {{21{sign}}, inst_fd[30:20]};
    assign imm_s = {{21{sign}}, inst_fd[30:25], inst_fd[11:7]};
    assign imm_b = {{20{sign}}, inst_fd[7], inst_fd[30:25], inst_fd[11:8], 1'b0};
    assign imm_u = {inst_fd[31:12], 12'b0};
    assign imm_j = {{12{sign}}, inst_fd[19:12], inst_fd[20], inst_fd[30:21], 1'b0};

    assign jalr_sum = reg_d_rs1 + imm_i;

    always_comb begin
        alu_d       = 1'b0;
        alu_imm_f_d = 1'b0;
        mem_d       = 1'b0;
        branch_d    = 1'b0;
        jump_d      = 1'b0;
        subst_d     = 1'b0;
        d_rs1_d     = reg_d_rs1;
        d_rs2_d     = reg_d_rs2;
        d_rs3_d     = '0;
        case (opecode_d)
            OP_ALU: alu_d = 1'b1;
            OP_ALUI: begin
                alu_d       = 1'b1;
                alu_imm_f_d = 1'b1;
                d_rs2_d     = imm_i;
            end
            OP_LOAD: begin
                mem_d   = 1'b1;
                d_rs1_d = reg_d_rs1 + imm_i;
            end
            OP_STORE: begin
                // store data stays on d_rs2
                mem_d   = 1'b1;
                d_rs1_d = reg_d_rs1 + imm_s;
            end
            OP_BRANCH: begin
                branch_d = 1'b1;
                d_rs3_d  = pc_fd + imm_b;
            end
            OP_JAL: begin
                jump_d  = 1'b1;
                d_rs1_d = pc_fd + imm_j;
            end
            OP_JALR: begin
                jump_d  = 1'b1;
                d_rs1_d = {jalr_sum[31:1], 1'b0};
            end
            OP_LUI: begin
                subst_d = 1'b1;
                d_rs3_d = imm_u;
            end
            OP_AUIPC: begin
                subst_d = 1'b1;
                d_rs3_d = pc_fd + imm_u;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/fetch.sv
`include "cpu_cfg.svh"

`default_nettype none

module fetch
    import cpu_pkg::*;
(
    input  wire        clk,
    input  wire        rstn,
    input  wire        fetch_order,
    output logic       fetched,
    input  wire word_t pc,
    output inst_t      inst_f,
    output iaddr_t     a_inst,
    input  wire inst_t d_inst
);

    localparam word_t RESET_WORD = `RESET_PC;

    // high while the memory read is outstanding
    logic busy;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            fetched <= 1'b0;
            a_inst  <= RESET_WORD[`LEN_MEMISTR_ADDR+1:2];
        end else begin
            fetched <= 1'b0;
            if (fetch_order) begin
                a_inst <= pc[`LEN_MEMISTR_ADDR+1:2];
                busy   <= 1'b1;
            end else if (busy) begin
                // memory answers one cycle after the address
                busy    <= 1'b0;
                fetched <= 1'b1;
            end
        end
    end

    // word is valid in the cycle fetched is high
    assign inst_f = d_inst;

endmodule

`default_nettype wire

//--- hdl/memory.sv
`include "cpu_cfg.svh"

`default_nettype none

module memory
    import cpu_pkg::*;
(
    input  wire         clk,
    input  wire         rstn,
    input  wire         mem_flag,
    input  wire         mem_io,
    input  wire func3_t func3,
    input  wire word_t  d_rs1,
    input  wire word_t  d_rs2,
    output word_t       d_dr_mem,
    output logic        mem_accessed,
    output daddr_t      a_mem,
    output word_t       sd_mem,
    input  wire word_t  ld_mem,
    output strobe_t     mem_write_flag,
    output logic        mem_read_flag
);

    logic [1:0]  offset;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    word_t       st_data;
    strobe_t     st_strobe;

    // replicate store data over the lanes, strobe picks the live ones
    always_comb begin
        case (func3)
            F3_B: begin
                st_data   = {4{d_rs2[7:0]}};
                st_strobe = 4'b0001 << d_rs1[1:0];
            end
            F3_H: begin
                st_data   = {2{d_rs2[15:0]}};
                st_strobe = d_rs1[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_data   = d_rs2;
                st_strobe = 4'b1111;
            end
        endcase
    end

    // one strobe cycle, then the done pulse
    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_write_flag <= '0;
            mem_read_flag  <= 1'b0;
            mem_accessed   <= 1'b0;
        end else begin
            mem_write_flag <= (mem_flag && mem_io) ? st_strobe : '0;
            mem_read_flag  <= mem_flag && !mem_io;
            mem_accessed   <= mem_read_flag || (mem_write_flag != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (mem_flag) begin
            a_mem  <= d_rs1[`LEN_MEMDATA_ADDR+1:2];
            offset <= d_rs1[1:0];
            sd_mem <= st_data;
        end
    end

    // lane select on the returned word
    assign ld_byte = ld_mem[{offset, 3'b000} +: 8];
    assign ld_half = offset[1] ? ld_mem[31:16] : ld_mem[15:0];

    always_comb begin
        case (func3)
            F3_B:  d_dr_mem = {{24{ld_byte[7]}}, ld_byte};
            F3_H:  d_dr_mem = {{16{ld_half[15]}}, ld_half};
            F3_BU: d_dr_mem = {24'b0, ld_byte};
            F3_HU: d_dr_mem = {16'b0, ld_half};
            default: d_dr_mem = ld_mem;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/regs.sv
`default_nettype none

module regs
    import cpu_pkg::*;
(
    input  wire            clk,
    input  wire            rstn,
    input  wire            reg_flag,
    input  wire reg_addr_t reg_a_rd,
    input  wire word_t     reg_d_rd,
    input  wire reg_addr_t reg_a_rs1,
    input  wire reg_addr_t reg_a_rs2,
    output word_t          reg_d_rs1,
    output word_t          reg_d_rs2
);

    word_t rf [32];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (reg_flag && (reg_a_rd != '0)) begin
            rf[reg_a_rd] <= reg_d_rd;
        end
    end

    // x0 always reads as zero
    assign reg_d_rs1 = (reg_a_rs1 == '0) ? '0 : rf[reg_a_rs1];
    assign reg_d_rs2 = (reg_a_rs2 == '0) ? '0 : rf[reg_a_rs2];

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/regs.sv
hdl/fetch.sv
hdl/decode.sv
hdl/alu.sv
hdl/memory.sv
hdl/cpu.sv
tests/tb_cpu.sv

//--- tests/cpu_trace.txt
// I byte_addr word : program | D byte_addr word : initial data
// S byte_addr strobe data : expected store, data zero outside the strobe; # names the test
I 000 FFB00093
I 004 00700113
I 008 002081B3
I 00C 10302023
I 010 40208233
I 014 10402223
I 018 0020A2B3
I 01C 0020B333
I 020 10502423
I 024 10602623
I 028 4010D393
I 02C 01C0D413
I 030 00411493
I 034 00944533
I 038 10702823
I 03C 10A02A23
I 040 0F00F593
I 044 0025E5B3
I 048 10B02C23
I 04C 12345637
I 050 00001697
I 054 06300013
I 058 10C02E23
I 05C 12D02023
I 060 12002223
I 064 20000703
I 068 12E02423
I 06C 20104703
I 070 12E02623
I 074 20200703
I 078 12E02823
I 07C 20304703
I 080 12E02A23
I 084 20201703
I 088 12E02C23
I 08C 20005703
I 090 12E02E23
I 094 A1B2C7B7
I 098 3D478793
I 09C 14F000A3
I 0A0 14F001A3
I 0A4 14F01123
I 0A8 14F01223
I 0AC 14F00323
I 0B0 00000463
I 0B4 18002023
I 0B8 00209463
I 0BC 18002023
I 0C0 0020C463
I 0C4 18002023
I 0C8 00115463
I 0CC 18002023
I 0D0 00116463
I 0D4 18002023
I 0D8 0020F463
I 0DC 18002023
I 0E0 00208463
I 0E4 18202223
I 0E8 00001463
I 0EC 18202223
I 0F0 00114463
I 0F4 18202223
I 0F8 0020D463
I 0FC 18202223
I 100 0020E463
I 104 18202223
I 108 00117463
I 10C 18202223
I 110 00C0086F
I 114 18002023
I 118 18002023
I 11C 19002423
I 120 12D008E7
I 124 18002023
I 128 18002023
I 12C 19102623
I 130 00000F8B
I 134 19F02823
I 138 0000006F
D 200 80F17F85
# alu
S 100 F 00000002
S 104 F FFFFFFF4
S 108 F 00000001
S 10C F 00000000
S 110 F FFFFFFFD
S 114 F 0000007F
S 118 F 000000F7
S 11C F 12345000
S 120 F 00001050
S 124 F 00000000
# loads
S 128 F FFFFFF85
S 12C F 0000007F
S 130 F FFFFFFF1
S 134 F 00000080
S 138 F FFFF80F1
S 13C F 00007F85
# narrow_stores
S 140 2 0000D400
S 140 8 D4000000
S 140 C C3D40000
S 144 3 0000C3D4
S 144 4 00D40000
# branches
S 184 F 00000007
S 184 F 00000007
S 184 F 00000007
S 184 F 00000007
S 184 F 00000007
S 184 F 00000007
# jumps
S 188 F 00000114
S 18C F 00000124
# unknown_opcode
S 190 F 00000000

//--- tests/tb_cpu.sv
`include "cpu_cfg.svh"

`default_nettype none

module tb_cpu
    import cpu_pkg::*;
();

    localparam int STORE_TIMEOUT = 400;
    localparam int QUIET_CYCLES  = 200;

    logic    clk;
    logic    rstn;
    iaddr_t  a_inst;
    inst_t   d_inst;
    daddr_t  a_mem;
    word_t   sd_mem;
    word_t   ld_mem;
    strobe_t mem_write_flag;
    logic    mem_read_flag;

    inst_t imem [2**`LEN_MEMISTR_ADDR];
    word_t dmem [2**`LEN_MEMDATA_ADDR];

    // expected stores in program order
    word_t   exp_addr [$];
    strobe_t exp_strb [$];
    word_t   exp_data [$];
    string   exp_name [$];

    int errors;
    int tests_pass;
    int tests_fail;
    bit aborted;

    cpu cpu_inst (
        .clk(clk), .rstn(rstn), .a_inst(a_inst), .d_inst(d_inst), .a_mem(a_mem),
        .sd_mem(sd_mem), .ld_mem(ld_mem), .mem_write_flag(mem_write_flag),
        .mem_read_flag(mem_read_flag)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // both memories answer on the falling edge
    always @(negedge clk) begin
        for (int k = 0; k < 4; k++) begin
            if (mem_write_flag[k]) begin
                dmem[a_mem][8*k +: 8] <= sd_mem[8*k +: 8];
            end
        end
        d_inst <= imem[a_inst];
        ld_mem <= dmem[a_mem];
    end

    task automatic check_word(input string sig, input word_t exp, input word_t got);
        if (exp !== got) begin
            $display("ERR %0t %s expected %h observed %h", $time, sig, exp, got);
            errors++;
        end
    endtask

    task automatic check_strobe(input string sig, input strobe_t exp, input strobe_t got);
        if (exp !== got) begin
            $display("ERR %0t %s expected %b observed %b", $time, sig, exp, got);
            errors++;
        end
    endtask

    task automatic check_daddr(input string sig, input daddr_t exp, input daddr_t got);
        if (exp !== got) begin
            $display("ERR %0t %s expected %h observed %h", $time, sig, exp, got);
            errors++;
        end
    endtask

    task automatic check_iaddr(input string sig, input iaddr_t exp, input iaddr_t got);
        if (exp !== got) begin
            $display("ERR %0t %s expected %h observed %h", $time, sig, exp, got);
            errors++;
        end
    endtask

    task automatic check_bit(input string sig, input logic exp, input logic got);
        if (exp !== got) begin
            $display("ERR %0t %s expected %b observed %b", $time, sig, exp, got);
            errors++;
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    code;
        bit    bad;
        string line;
        string name;
        word_t a;
        word_t b;
        word_t c;
        begin
            name = "unnamed";
            fd = $fopen("tests/cpu_trace.txt", "r");
            if (fd == 0) begin
                $display("cannot open tests/cpu_trace.txt");
                aborted = 1'b1;
            end else begin
                while (!$feof(fd)) begin
                    line = "";
                    code = $fgets(line, fd);
                    bad  = 1'b0;
                    if (code > 0) begin
                        if (line[0] == "I") begin
                            code = $sscanf(line, "I %h %h", a, b);
                            bad  = (code != 2);
                            imem[a[`LEN_MEMISTR_ADDR+1:2]] = b;
                        end else if (line[0] == "D") begin
                            code = $sscanf(line, "D %h %h", a, b);
                            bad  = (code != 2);
                            dmem[a[`LEN_MEMDATA_ADDR+1:2]] = b;
                        end else if (line[0] == "S") begin
                            code = $sscanf(line, "S %h %h %h", a, b, c);
                            bad  = (code != 3);
                            exp_addr.push_back(a);
                            exp_strb.push_back(strobe_t'(b));
                            exp_data.push_back(c);
                            exp_name.push_back(name);
                        end else if (line[0] == "#") begin
                            code = $sscanf(line, "# %s", name);
                            bad  = (code != 1);
                        end
                    end
                    if (bad) begin
                        $display("malformed record in tests/cpu_trace.txt: %s", line);
                        aborted = 1'b1;
                    end
                end
                $fclose(fd);
            end
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_pass++;
            $display("test %s: pass", name);
        end else begin
            tests_fail++;
            $display("test %s: fail", name);
        end
    endtask

    // wait for the next strobe cycle within a bounded count
    task automatic wait_store(input int idx, output bit found);
        int n;
        begin
            found = 1'b0;
            n = 0;
            while (!found && n < STORE_TIMEOUT) begin
                @(negedge clk);
                if (mem_write_flag != '0) begin
                    found = 1'b1;
                end
                n++;
            end
            if (!found) begin
                $display("store %0d of test %s never came, controller in phase %s",
                    idx, exp_name[idx], cpu_inst.phase.name());
            end
        end
    endtask

    initial begin
        int      start_errs;
        bit      found;
        word_t   mask;
        word_t   word_addr;
        rstn       = 1'b0;
        d_inst     = '0;
        ld_mem     = '0;
        errors     = 0;
        tests_pass = 0;
        tests_fail = 0;
        aborted    = 1'b0;
        // unprogrammed data words carry their own index
        for (int i = 0; i < 2**`LEN_MEMDATA_ADDR; i++) begin
            dmem[i] = 32'ha500_0000 | i;
        end
        for (int i = 0; i < 2**`LEN_MEMISTR_ADDR; i++) begin
            imem[i] = '0;
        end
        load_trace();

        // reset and the first fetch address
        start_errs = errors;
        @(negedge clk);
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_strobe("mem_write_flag", '0, mem_write_flag);
            check_bit("mem_read_flag", 1'b0, mem_read_flag);
            if (i == 3) begin
                rstn = 1'b1;
            end
        end
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            check_iaddr("a_inst", '0, a_inst);
            check_strobe("mem_write_flag", '0, mem_write_flag);
            check_bit("mem_read_flag", 1'b0, mem_read_flag);
        end
        end_test("reset", start_errs);

        start_errs = errors;
        for (int i = 0; i < exp_addr.size() && !aborted; i++) begin
            wait_store(i, found);
            if (!found) begin
                aborted = 1'b1;
                errors++;
                end_test(exp_name[i], start_errs);
            end else begin
                mask = {{8{exp_strb[i][3]}}, {8{exp_strb[i][2]}},
                        {8{exp_strb[i][1]}}, {8{exp_strb[i][0]}}};
                word_addr = exp_addr[i] >> 2;
                check_daddr("a_mem", daddr_t'(word_addr), a_mem);
                check_strobe("mem_write_flag", exp_strb[i], mem_write_flag);
                check_word("sd_mem", exp_data[i], sd_mem & mask);
                if (i == exp_addr.size() - 1 || exp_name[i + 1] != exp_name[i]) begin
                    end_test(exp_name[i], start_errs);
                    start_errs = errors;
                end
            end
        end

        // program parks in a self-jump and writes nothing more
        if (!aborted) begin
            start_errs = errors;
            for (int i = 0; i < QUIET_CYCLES; i++) begin
                @(negedge clk);
                check_strobe("mem_write_flag", '0, mem_write_flag);
            end
            end_test("quiet", start_errs);
        end

        $display("tests passed %0d failed %0d", tests_pass, tests_fail);
        if (tests_fail == 0 && errors == 0 && !aborted) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
